// File: smc_pkg.sv
/* Static memory controller package
   AHB-lite encodings, interface FSM states and fixed timing/width constants */

package smc_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned ADDR_W = 32;  // AHB and EMI address
  localparam int unsigned DATA_W = 32;  // AHB and EMI data
  localparam int unsigned BE_W   = DATA_W / 8;  // Byte lanes

  // ----------------------------------------------------------
  // Access timing, in hclk cycles
  // ----------------------------------------------------------
  localparam int unsigned T_STROBE  = 3;             // Strobe cycles per access
  localparam int unsigned T_ACCESS  = T_STROBE + 2;  // Setup + strobes + hold
  localparam int unsigned STB_CNT_W = $clog2(T_STROBE + 1);

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11  // Handled as single transfer
  } htrans_e;

  // AHB transfer size
  typedef enum logic [2:0] {
    BYTE    = 3'b000,
    HALF    = 3'b001,
    WORD    = 3'b010,
    DWORD   = 3'b011,  // Wider than the bus, illegal here
    LINE4W  = 3'b100,
    LINE8W  = 3'b101,
    LINE16W = 3'b110,
    LINE32W = 3'b111
  } hsize_e;

  // AHB-lite response
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  // External memory interface sequencing
  typedef enum logic [1:0] {
    EMI_IDLE   = 2'b00,
    EMI_SETUP  = 2'b01,  // CS and address out
    EMI_STROBE = 2'b10,  // RD or WR/WE low
    EMI_HOLD   = 2'b11   // Strobes released, AHB completes
  } emi_state_e;

endpackage

// File: smc_ahb_if.sv
/* AHB-lite slave of the static memory controller
   Qualifies address phases, checks alignment, decodes lanes and builds the response */

`timescale 1ns/1ps

module smc_ahb_if import smc_pkg::*; (
  input  logic              hclk,
  input  logic              arst_n,
  input  logic              hsel,        // Slave select
  input  logic [ADDR_W-1:0] haddr,
  input  htrans_e           htrans,
  input  logic              hwrite,
  input  hsize_e            hsize,
  input  logic              hready,      // Muxed bus ready
  input  logic              done,        // Hold cycle of the EMI access
  input  logic [DATA_W-1:0] rd_data,
  output logic              start,       // Kicks the EMI FSM
  output logic              acc_write,
  output logic [ADDR_W-1:0] acc_addr,
  output logic [BE_W-1:0]   acc_n_be,    // Active-low lanes
  output logic [DATA_W-1:0] smc_hrdata,
  output logic              smc_hready,
  output hresp_e            smc_hresp,
  output logic              smc_valid    // Legal transfer taken
);

  logic accept;    // Address phase taken this edge
  logic legal;     // Size/alignment ok
  logic pend_q;    // EMI access outstanding
  logic start_q;
  logic err1_q;    // First ERROR cycle, hready low
  logic err2_q;    // Second ERROR cycle, hready high

  // Alignment check against transfer size
  function automatic logic legal_xfer(input logic [1:0] a, input hsize_e sz);
    case (sz)
      BYTE:    legal_xfer = 1'b1;
      HALF:    legal_xfer = ~a[0];
      WORD:    legal_xfer = (a == 2'b00);
      default: legal_xfer = 1'b0;  // Wider than a word
    endcase
  endfunction

  // Little-endian lane decode, active low
  function automatic logic [BE_W-1:0] lane_n_be(input logic [1:0] a, input hsize_e sz);
    case (sz)
      BYTE:    lane_n_be = ~(BE_W'(1) << a);
      HALF:    lane_n_be = ~(BE_W'(3) << a);
      default: lane_n_be = '0;  // All four lanes
    endcase
  endfunction

  assign accept = hsel && (htrans == NONSEQ || htrans == SEQ) && hready;
  assign legal  = legal_xfer(haddr[1:0], hsize);

  // ----------------------------------------------------------
  // Transfer capture and start pulse
  // ----------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q    <= 1'b0;
      start_q   <= 1'b0;
      acc_write <= 1'b0;
      acc_n_be  <= '1;
    end else begin
      start_q <= accept && legal;  // One cycle, lands on setup
      if (accept && legal) begin
        pend_q    <= 1'b1;
        acc_write <= hwrite;
        acc_n_be  <= lane_n_be(haddr[1:0], hsize);
      end else if (done) begin
        pend_q   <= 1'b0;
        acc_n_be <= '1;  // Lanes idle between accesses
      end
    end
  end

  // Transfer address, held for the whole access
  always_ff @(posedge hclk) begin
    if (accept && legal) begin
      acc_addr <= haddr;
    end
  end

  // ----------------------------------------------------------
  // Two-cycle ERROR response
  // ----------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      err1_q <= 1'b0;
      err2_q <= 1'b0;
    end else begin
      err1_q <= accept && !legal;
      err2_q <= err1_q;
    end
  end

  assign start      = start_q;
  assign smc_valid  = start_q;                             // Same cycle as setup
  assign smc_hready = !(pend_q && !done) && !err1_q;      // Low until hold
  assign smc_hresp  = (err1_q || err2_q) ? ERROR : OKAY;
  assign smc_hrdata = rd_data;                             // Valid from hold

  // Second ERROR cycle must follow the first
  a_err_two_cycle : assert property (@(posedge hclk) disable iff (!arst_n)
    (smc_hresp == ERROR && smc_hready) |-> $past(smc_hresp == ERROR));

  // No new access until the EMI reports done
  a_start_idle : assert property (@(posedge hclk) disable iff (!arst_n)
    start |-> $past(!pend_q || done));

endmodule

// File: smc_emi_fsm.sv
/* External memory interface sequencer
   Drives chip select, strobes, write data and read capture for one access */

`timescale 1ns/1ps

module smc_emi_fsm import smc_pkg::*; (
  input  logic              hclk,
  input  logic              arst_n,
  input  logic              start,         // Setup cycle of a new access
  input  logic              acc_write,
  input  logic [ADDR_W-1:0] acc_addr,
  input  logic [BE_W-1:0]   acc_n_be,
  input  logic [DATA_W-1:0] hwdata,        // AHB write data, first data cycle
  input  logic [DATA_W-1:0] data_smc,      // Device read data
  output logic              done,          // Hold cycle
  output logic [DATA_W-1:0] rd_data,
  output logic [ADDR_W-1:0] smc_addr,
  output logic [DATA_W-1:0] smc_data,
  output logic [BE_W-1:0]   smc_n_be,
  output logic              smc_n_cs,
  output logic [BE_W-1:0]   smc_n_we,      // Per-lane write strobes
  output logic              smc_n_wr,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,  // Write data drive enable
  output logic              smc_busy
);

  emi_state_e             state_q;   // Registered state
  emi_state_e             state;     // Current state, setup included
  emi_state_e             state_d;
  logic [STB_CNT_W-1:0]   cnt_q;     // Strobe cycle count
  logic                   last_stb;
  logic                   n_rd_q;
  logic                   n_wr_q;
  logic [BE_W-1:0]        n_we_q;
  logic                   n_ext_oe_q;
  logic [DATA_W-1:0]      wdata_q;
  logic [DATA_W-1:0]      rdata_q;

  // Setup overlaps the start pulse, state_q is idle then
  assign state    = start ? EMI_SETUP : state_q;
  assign last_stb = (state == EMI_STROBE) && (cnt_q == STB_CNT_W'(T_STROBE - 1));

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state;
    case (state)
      EMI_SETUP:  state_d = EMI_STROBE;
      EMI_STROBE: begin
        if (last_stb) begin
          state_d = EMI_HOLD;
        end
      end
      EMI_HOLD:   state_d = EMI_IDLE;
      default:    state_d = EMI_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= EMI_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state == EMI_STROBE && !last_stb) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;  // Ready for next access
      end
    end
  end

  // ----------------------------------------------------------
  // Strobes, registered from next state
  // ----------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      n_rd_q     <= 1'b1;
      n_wr_q     <= 1'b1;
      n_we_q     <= '1;
      n_ext_oe_q <= 1'b1;
    end else begin
      n_rd_q     <= !(state_d == EMI_STROBE && !acc_write);
      n_wr_q     <= !(state_d == EMI_STROBE && acc_write);
      n_we_q     <= (state_d == EMI_STROBE && acc_write) ? acc_n_be : '1;
      // Drive bus through strobe and hold of a write
      n_ext_oe_q <= !(acc_write && (state_d == EMI_STROBE || state_d == EMI_HOLD));
    end
  end

  // Write data at end of setup, read data at end of last strobe
  always_ff @(posedge hclk) begin
    if (state == EMI_SETUP && acc_write) begin
      wdata_q <= hwdata;
    end
    if (last_stb && !acc_write) begin
      rdata_q <= data_smc;
    end
  end

  assign done         = (state_q == EMI_HOLD);
  assign rd_data      = rdata_q;
  assign smc_addr     = acc_addr;   // Held from setup through hold
  assign smc_n_be     = acc_n_be;   // All ones between accesses
  assign smc_data     = wdata_q;
  assign smc_n_cs     = (state == EMI_IDLE);
  assign smc_n_rd     = n_rd_q;
  assign smc_n_wr     = n_wr_q;
  assign smc_n_we     = n_we_q;
  assign smc_n_ext_oe = n_ext_oe_q;
  assign smc_busy     = (state != EMI_IDLE);

  // Read and write strobes are exclusive
  a_rd_wr_excl : assert property (@(posedge hclk) disable iff (!arst_n)
    !(!smc_n_rd && !smc_n_wr));

  // Any strobe only inside chip select
  a_stb_in_cs : assert property (@(posedge hclk) disable iff (!arst_n)
    (!smc_n_rd || !smc_n_wr || smc_n_we != '1) |-> !smc_n_cs);

endmodule

// File: smc_lite.sv
/* Static memory controller core
   Joins the AHB slave to the external interface sequencer */

`timescale 1ns/1ps

module smc_lite import smc_pkg::*; (
  input  logic              hclk,
  input  logic              arst_n,
  // AHB slave side
  input  logic              hsel,
  input  logic [ADDR_W-1:0] haddr,
  input  htrans_e           htrans,
  input  logic              hwrite,
  input  hsize_e            hsize,
  input  logic [DATA_W-1:0] hwdata,
  input  logic              hready,
  output logic [DATA_W-1:0] smc_hrdata,
  output logic              smc_hready,
  output hresp_e            smc_hresp,
  output logic              smc_valid,
  // External memory side
  output logic [ADDR_W-1:0] smc_addr,
  output logic [DATA_W-1:0] smc_data,
  input  logic [DATA_W-1:0] data_smc,
  output logic [BE_W-1:0]   smc_n_be,
  output logic              smc_n_cs,
  output logic [BE_W-1:0]   smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  logic              start;      // AHB to EMI, setup cycle
  logic              done;       // EMI to AHB, hold cycle
  logic              acc_write;
  logic [ADDR_W-1:0] acc_addr;
  logic [BE_W-1:0]   acc_n_be;
  logic [DATA_W-1:0] rd_data;

  smc_ahb_if i_smc_ahb_if (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hready     (hready),
    .done       (done),
    .rd_data    (rd_data),
    .start      (start),
    .acc_write  (acc_write),
    .acc_addr   (acc_addr),
    .acc_n_be   (acc_n_be),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_valid  (smc_valid)
  );

  smc_emi_fsm i_smc_emi_fsm (
    .hclk         (hclk),
    .arst_n       (arst_n),
    .start        (start),
    .acc_write    (acc_write),
    .acc_addr     (acc_addr),
    .acc_n_be     (acc_n_be),
    .hwdata       (hwdata),     // Sampled at end of setup
    .data_smc     (data_smc),
    .done         (done),
    .rd_data      (rd_data),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr),
    .smc_n_rd     (smc_n_rd),
    .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy     (smc_busy)
  );

endmodule

// File: smc_veneer.sv
/* Static memory controller top level */

`timescale 1ns/1ps

module smc_veneer import smc_pkg::*; (
  input  logic              hclk,          // AHB system clock
  input  logic              arst_n,        // Async reset, active low
  // AHB
  input  logic              hsel,
  input  logic [ADDR_W-1:0] haddr,
  input  htrans_e           htrans,
  input  logic              hwrite,
  input  hsize_e            hsize,
  input  logic [DATA_W-1:0] hwdata,
  input  logic              hready,        // Muxed bus ready
  output logic [DATA_W-1:0] smc_hrdata,
  output logic              smc_hready,
  output hresp_e            smc_hresp,
  output logic              smc_valid,
  // External memory interface
  output logic [ADDR_W-1:0] smc_addr,
  output logic [DATA_W-1:0] smc_data,
  input  logic [DATA_W-1:0] data_smc,
  output logic [BE_W-1:0]   smc_n_be,
  output logic              smc_n_cs,
  output logic [BE_W-1:0]   smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,
  // Status
  output logic              smc_busy
);

  smc_lite i_smc_lite (
    .hclk (hclk), .arst_n (arst_n),
    .hsel (hsel), .haddr (haddr), .htrans (htrans), .hwrite (hwrite),
    .hsize (hsize), .hwdata (hwdata), .hready (hready),
    .smc_hrdata (smc_hrdata), .smc_hready (smc_hready),
    .smc_hresp (smc_hresp), .smc_valid (smc_valid),
    .smc_addr (smc_addr), .smc_data (smc_data), .data_smc (data_smc),
    .smc_n_be (smc_n_be), .smc_n_cs (smc_n_cs), .smc_n_we (smc_n_we),
    .smc_n_wr (smc_n_wr), .smc_n_rd (smc_n_rd), .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy (smc_busy)
  );

endmodule

// File: tb_smc_sram.sv
/* Behavioral asynchronous SRAM used as the external device
   256 words with byte write strobes, read data while chip select and read are low */

`timescale 1ns/1ps

module tb_smc_sram import smc_pkg::*; (
  input  logic [ADDR_W-1:0] smc_addr,
  input  logic [DATA_W-1:0] smc_data,
  input  logic              smc_n_cs,
  input  logic [BE_W-1:0]   smc_n_we,
  input  logic              smc_n_wr,
  input  logic              smc_n_rd,
  input  logic              smc_n_ext_oe,
  output logic [DATA_W-1:0] data_smc
);

  logic [DATA_W-1:0] mem [256];
  logic [BE_W-1:0]   we_lanes;  // Lanes of the current write strobe

  // Fill pattern over the whole word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i), {i[3:0], i[7:4]} ^ 8'hc3};
    end
  end

  // Lanes latched while the byte strobes are low
  always @(smc_n_we) begin
    if (smc_n_we != '1) begin
      we_lanes = ~smc_n_we;
    end
  end

  // Write lands on the rising edge of the write strobe
  always @(posedge smc_n_wr) begin
    if (!smc_n_cs) begin
      for (int k = 0; k < BE_W; k++) begin
        if (we_lanes[k]) begin
          mem[smc_addr[9:2]][8*k +: 8] <= smc_n_ext_oe ? 8'hxx : smc_data[8*k +: 8];
        end
      end
    end
  end

  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[smc_addr[9:2]] : '0;  // Parked low

endmodule

// File: tb_smc.sv
/* Testbench for the static memory controller
   AHB master, shadow memory reference and a bus monitor that checks each transfer */

`timescale 1ns/1ps

module tb_smc import smc_pkg::*; ();

  localparam int unsigned TIMEOUT = 20;   // Cycles allowed per wait
  localparam int unsigned N_RAND  = 300;  // Random transfers

  logic              hclk;
  logic              arst_n;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  htrans_e           htrans;
  logic              hwrite;
  hsize_e            hsize;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] smc_hrdata;
  logic              smc_hready;
  hresp_e            smc_hresp;
  logic              smc_valid;
  logic [ADDR_W-1:0] smc_addr;
  logic [DATA_W-1:0] smc_data;
  logic [DATA_W-1:0] data_smc;
  logic [BE_W-1:0]   smc_n_be;
  logic              smc_n_cs;
  logic [BE_W-1:0]   smc_n_we;
  logic              smc_n_wr;
  logic              smc_n_rd;
  logic              smc_n_ext_oe;
  logic              smc_busy;

  logic [DATA_W-1:0] shadow [256];  // Reference memory
  int unsigned       n_legal = 0;   // Accepted legal transfers
  int unsigned       n_valid = 0;   // smc_valid pulses
  logic              dp_act = 1'b0; // Data phase in flight
  logic              dp_legal;
  logic              dp_write;
  logic              dp_stb;        // Strobe window of a legal access
  logic [BE_W-1:0]   dp_n_be;       // Expected active-low lanes
  logic [ADDR_W-1:0] dp_addr;
  hsize_e            dp_size;
  int unsigned       dp_cycles;

  smc_veneer i_smc_veneer (
    .hclk, .arst_n, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata,
    .hready (smc_hready),  // Only slave on the bus
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid,
    .smc_addr, .smc_data, .data_smc, .smc_n_be, .smc_n_cs, .smc_n_we,
    .smc_n_wr, .smc_n_rd, .smc_n_ext_oe, .smc_busy
  );

  tb_smc_sram i_sram (
    .smc_addr, .smc_data, .smc_n_cs, .smc_n_we, .smc_n_wr, .smc_n_rd,
    .smc_n_ext_oe, .data_smc
  );

  initial begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;  // 50 MHz
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] i);
    return {i ^ 8'h5a, ~i, i, {i[3:0], i[7:4]} ^ 8'hc3};
  endfunction

  // Active-low lanes from offset up through the transfer size
  function automatic logic [BE_W-1:0] ref_lanes(input logic [1:0] off, input hsize_e size);
    int              nb;
    logic [BE_W-1:0] n_be;
    nb = 1 << int'(size);
    for (int k = 0; k < BE_W; k++) begin
      n_be[k] = !(k >= int'(off) && k < int'(off) + nb);
    end
    return n_be;
  endfunction

  function automatic logic ref_legal(input logic [1:0] off, input hsize_e size);
    return (size <= WORD) && (int'(off) % (1 << int'(size)) == 0);
  endfunction

  // New lanes over old word, also masks read data with old = 0
  function automatic logic [DATA_W-1:0] ref_merge(input logic [DATA_W-1:0] old, wdata,
                                                  input logic [BE_W-1:0] n_be);
    logic [DATA_W-1:0] word;
    word = old;
    for (int k = 0; k < BE_W; k++) begin
      if (!n_be[k]) begin
        word[8*k +: 8] = wdata[8*k +: 8];
      end
    end
    return word;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_resp(input string name, input hresp_e got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
      stop_failed();
    end
  endtask

  task automatic check_lanes(input string name, input logic [BE_W-1:0] got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_level(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input int unsigned got, exp);
    if (got != exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_failed();
    end
  endtask

  // Outputs of an idle controller, same as right after reset
  task automatic check_idle_values();
    check_level("smc_hready", smc_hready, 1'b1);
    check_resp("smc_hresp", smc_hresp, OKAY);
    check_level("smc_valid", smc_valid, 1'b0);
    check_level("smc_busy", smc_busy, 1'b0);
    check_level("smc_n_cs", smc_n_cs, 1'b1);
    check_level("smc_n_rd", smc_n_rd, 1'b1);
    check_level("smc_n_wr", smc_n_wr, 1'b1);
    check_level("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
    check_lanes("smc_n_we", smc_n_we, '1);
    check_lanes("smc_n_be", smc_n_be, '1);
  endtask

  // ----------------------------------------------------------
  // Bus monitor, sampled mid-cycle
  // ----------------------------------------------------------
  task automatic finish_phase();
    logic [7:0] idx;
    idx    = dp_addr[9:2];
    dp_act = 1'b0;
    check_count("data phase cycles", dp_cycles, dp_legal ? T_ACCESS : 2);
    check_resp("smc_hresp", smc_hresp, dp_legal ? OKAY : ERROR);
    if (dp_legal && dp_write) begin
      shadow[idx] = ref_merge(shadow[idx], hwdata, dp_n_be);
    end
    if (dp_legal && !dp_write) begin
      check_data("smc_hrdata", ref_merge('0, smc_hrdata, dp_n_be),
                 ref_merge('0, shadow[idx], dp_n_be));
    end
  endtask

  always @(negedge hclk) begin
    if (arst_n) begin
      if (smc_valid) n_valid++;
      if (!dp_act) begin  // Idle bus, nothing may start
        check_idle_values();
      end else begin
        dp_cycles++;
        if (dp_cycles == 1) begin
          check_level("smc_valid", smc_valid, dp_legal);
          check_level("smc_hready", smc_hready, 1'b0);
          check_resp("smc_hresp", smc_hresp, dp_legal ? OKAY : ERROR);
        end
        // Setup is cycle 1, strobes follow, hold is last
        dp_stb = dp_legal && dp_cycles > 1 && dp_cycles <= T_STROBE + 1;
        check_level("smc_n_cs", smc_n_cs, !dp_legal);  // Error starts no access
        check_level("smc_busy", smc_busy, dp_legal);
        check_level("smc_n_rd", smc_n_rd, !(dp_stb && !dp_write));
        check_level("smc_n_wr", smc_n_wr, !(dp_stb && dp_write));
        check_lanes("smc_n_we", smc_n_we, (dp_stb && dp_write) ? dp_n_be : '1);
        check_level("smc_n_ext_oe", smc_n_ext_oe, !(dp_legal && dp_write && dp_cycles > 1));
        if (dp_legal) begin
          check_addr("smc_addr", smc_addr, dp_addr);
          check_lanes("smc_n_be", smc_n_be, dp_n_be);
        end
        if (dp_legal && dp_write && dp_cycles > 1) begin
          check_data("smc_data", smc_data, hwdata);  // Captured at end of setup
        end
        if (smc_hready) begin
          finish_phase();
        end else if (dp_cycles > TIMEOUT) begin
          $display("Data phase did not complete within %0d cycles", TIMEOUT);
          stop_failed();
        end
      end
      // Address phase seen now is taken at the next rising edge
      if (smc_hready && hsel && (htrans == NONSEQ || htrans == SEQ)) begin
        dp_act    = 1'b1;
        dp_cycles = 0;
        dp_addr   = haddr;
        dp_size   = hsize;
        dp_write  = hwrite;
        dp_legal  = ref_legal(haddr[1:0], hsize);
        dp_n_be   = ref_lanes(haddr[1:0], hsize);
        if (dp_legal) n_legal++;
      end
    end
  end

  // ----------------------------------------------------------
  // AHB master
  // ----------------------------------------------------------
  task automatic wait_ready(input string what);
    int unsigned n;
    n = 0;
    do begin
      @(negedge hclk);
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout waiting for %s", what);
        stop_failed();
      end
    end while (!smc_hready);
  endtask

  task automatic ahb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input hsize_e size, input logic [DATA_W-1:0] wdata);
    @(posedge hclk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= NONSEQ;
    hwrite <= write;
    hsize  <= size;
    wait_ready("address phase acceptance");
    @(posedge hclk);  // Acceptance edge
    hsel   <= 1'b0;
    htrans <= IDLE;
    hwdata <= wdata;  // Data phase
    wait_ready("data phase completion");
    @(posedge hclk);
  endtask

  // IDLE, BUSY or a NONSEQ with hsel low
  task automatic idle_gap(input int unsigned n);
    repeat (n) begin
      @(posedge hclk);
      case ($urandom_range(2, 0))
        0: begin
          hsel   <= 1'b1;
          htrans <= IDLE;
        end
        1: begin
          hsel   <= 1'b1;
          htrans <= BUSY;
        end
        default: begin
          hsel   <= 1'b0;
          htrans <= NONSEQ;
          haddr  <= $urandom();
          hwrite <= 1'($urandom_range(1, 0));
        end
      endcase
    end
  endtask

  // ----------------------------------------------------------
  // Scenarios
  // ----------------------------------------------------------
  initial begin
    logic [ADDR_W-1:0] addr;
    logic [1:0]        off;
    hsize_e            size;
    void'($urandom(32'h4ddc2772));
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(8'(i));
    end
    arst_n <= 1'b0;
    hsel   <= 1'b0;
    haddr  <= '0;
    htrans <= IDLE;
    hwrite <= 1'b0;
    hsize  <= WORD;
    hwdata <= '0;
    repeat (3) @(posedge hclk);
    @(negedge hclk);
    check_idle_values();
    @(posedge hclk);
    arst_n <= 1'b1;  // Released after 4 cycles
    @(negedge hclk);
    check_idle_values();

    // Word write and read back
    ahb_transfer(1'b1, 32'h0000_0040, WORD, 32'hcafe_f00d);
    ahb_transfer(1'b0, 32'h0000_0040, WORD, '0);

    // Byte and halfword lanes, merged word read after each
    for (int o = 0; o < 4; o++) begin
      ahb_transfer(1'b1, ADDR_W'(32'h80 + o), BYTE, $urandom());
      ahb_transfer(1'b0, 32'h80, WORD, '0);
    end
    for (int o = 0; o < 4; o += 2) begin
      ahb_transfer(1'b1, ADDR_W'(32'h84 + o), HALF, $urandom());
      ahb_transfer(1'b0, 32'h84, WORD, '0);
    end

    // Misaligned and oversized transfers
    ahb_transfer(1'b1, 32'h0c0, WORD, 32'h1234_5678);
    for (int o = 1; o < 4; o++) begin
      ahb_transfer(1'b1, ADDR_W'(32'h0c0 + o), WORD, '1);
      if (o[0]) ahb_transfer(1'($urandom_range(1, 0)), ADDR_W'(32'h0c0 + o), HALF, '1);
    end
    for (int s = 3; s < 8; s++) begin
      ahb_transfer(s[0], 32'h0c0, hsize_e'(s), '1);
    end
    ahb_transfer(1'b0, 32'h0c0, WORD, '0);  // Still the old word

    // Random legal traffic with gaps
    repeat (N_RAND) begin
      size = hsize_e'($urandom_range(2, 0));
      off  = 2'($urandom_range(3, 0));
      if (size == HALF) off[0] = 1'b0;
      if (size == WORD) off = 2'b00;
      addr = {22'($urandom()), 4'h0, 4'($urandom_range(15, 0)), off};
      ahb_transfer(1'($urandom_range(1, 0)), addr, size, $urandom());
      idle_gap($urandom_range(3, 0));
    end

    repeat (3) @(negedge hclk);
    if (n_valid == n_legal) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("** Error at %0t: smc_valid pulses = %0d, expected %0d", $time, n_valid, n_legal);
      stop_failed();
    end
  end

endmodule

// File: verilog.f
smc_pkg.sv
smc_ahb_if.sv
smc_emi_fsm.sv
smc_lite.sv
smc_veneer.sv
tb_smc_sram.sv
tb_smc.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_smc
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "FAIL: no result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
